//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and register file.
`define RV_XLEN         32
`define RV_ILEN         32
`define RV_REG_AW       5
`define RV_NUM_REGS     32
`define RV_SHAMT_W      5
`define RV_COUNT_W      32

// Instruction field positions.
`define RV_OPCODE_LSB   0
`define RV_RD_LSB       7
`define RV_FUNCT3_LSB   12
`define RV_RS1_LSB      15
`define RV_RS2_LSB      20
`define RV_FUNCT7_LSB   25

// Field widths.
`define RV_OPCODE_W     7
`define RV_FUNCT3_W     3
`define RV_FUNCT7_W     7
`define RV_IMM_I_W      12
`define RV_IMM_U_W      20

// ALU operation select width.
`define RV_ALU_OP_W     4

`endif

//--- rv_isa_pkg.sv
`include "rv_consts.svh"

package rv_isa_pkg;

    // Major opcodes kept in this core.
    typedef enum logic [`RV_OPCODE_W-1:0]
    {
        OPC_OP      = 7'b011_0011,
        OPC_OP_IMM  = 7'b001_0011,
        OPC_LUI     = 7'b011_0111
    } opcode_t;

    typedef enum logic [`RV_FUNCT3_W-1:0]
    {
        F3_ADD_SUB  = 3'b000,
        F3_SLL      = 3'b001,
        F3_SLT      = 3'b010,
        F3_SLTU     = 3'b011,
        F3_XOR      = 3'b100,
        F3_SRL_SRA  = 3'b101,
        F3_OR       = 3'b110,
        F3_AND      = 3'b111
    } funct3_t;

    typedef enum logic [`RV_FUNCT7_W-1:0]
    {
        F7_BASE     = 7'b000_0000,
        F7_ALT      = 7'b010_0000   // SUB and SRA.
    } funct7_t;

    typedef enum logic [`RV_ALU_OP_W-1:0]
    {
        ALU_ADD     = 4'd0,
        ALU_SUB     = 4'd1,
        ALU_SLL     = 4'd2,
        ALU_SLT     = 4'd3,
        ALU_SLTU    = 4'd4,
        ALU_XOR     = 4'd5,
        ALU_SRL     = 4'd6,
        ALU_SRA     = 4'd7,
        ALU_OR      = 4'd8,
        ALU_AND     = 4'd9,
        ALU_PASS_B  = 4'd10         // LUI.
    } alu_op_t;

endpackage

//--- rv_pipe_pkg.sv
`include "rv_consts.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0]      word_t;
    typedef logic [`RV_REG_AW-1:0]    reg_addr_t;
    typedef logic [`RV_ILEN-1:0]      instr_t;
    typedef logic [`RV_COUNT_W-1:0]   count_t;
    typedef logic [`RV_ALU_OP_W-1:0]  alu_sel_t;

    // Decoded instruction with its register operands.
    typedef struct packed
    {
        logic       valid;
        logic       illegal;
        alu_sel_t   alu_op;
        logic       use_imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
        word_t      rs1_data;
        word_t      rs2_data;
    } dec_t;

    // Result entry, shared by execute and result stages.
    typedef struct packed
    {
        logic       valid;
        logic       illegal;
        reg_addr_t  rd;
        word_t      data;
    } wb_t;

endpackage

//--- rv_decode.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_decode
    import rv_pipe_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst,
    input  wire         i_instr_valid,
    input  instr_t      i_instr,
    output reg_addr_t   o_rs1_addr,
    output reg_addr_t   o_rs2_addr,
    input  word_t       i_rs1_data,
    input  word_t       i_rs2_data,
    output dec_t        o_dec
);

    opcode_t    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm;
    alu_op_t    base_op;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       illegal;

    assign opcode     = opcode_t'(i_instr[`RV_OPCODE_LSB +: `RV_OPCODE_W]);
    assign funct3     = funct3_t'(i_instr[`RV_FUNCT3_LSB +: `RV_FUNCT3_W]);
    assign funct7     = funct7_t'(i_instr[`RV_FUNCT7_LSB +: `RV_FUNCT7_W]);
    assign rd         = i_instr[`RV_RD_LSB +: `RV_REG_AW];
    assign o_rs1_addr = i_instr[`RV_RS1_LSB +: `RV_REG_AW];
    assign o_rs2_addr = i_instr[`RV_RS2_LSB +: `RV_REG_AW];

    assign imm_i = word_t'($signed(i_instr[`RV_RS2_LSB +: `RV_IMM_I_W]));
    assign imm_u = {i_instr[`RV_FUNCT3_LSB +: `RV_IMM_U_W], {`RV_FUNCT3_LSB{1'b0}}};

    // Operation for the base funct7 encoding.
    always_comb
    begin
        case (funct3)
            F3_SLL:     base_op = ALU_SLL;
            F3_SLT:     base_op = ALU_SLT;
            F3_SLTU:    base_op = ALU_SLTU;
            F3_XOR:     base_op = ALU_XOR;
            F3_SRL_SRA: base_op = ALU_SRL;
            F3_OR:      base_op = ALU_OR;
            F3_AND:     base_op = ALU_AND;
            default:    base_op = ALU_ADD;
        endcase
    end

    always_comb
    begin
        alu_op  = base_op;
        use_imm = 1'b0;
        illegal = 1'b0;
        imm     = imm_i;
        case (opcode)
            OPC_OP:
            begin
                if (funct7 == F7_ALT && funct3 == F3_ADD_SUB)
                    alu_op = ALU_SUB;
                else if (funct7 == F7_ALT && funct3 == F3_SRL_SRA)
                    alu_op = ALU_SRA;
                else if (funct7 != F7_BASE)
                    illegal = 1'b1;
            end
            OPC_OP_IMM:
            begin
                use_imm = 1'b1;
                // Only shifts carry funct7 in the immediate.
                if (funct3 == F3_SRL_SRA && funct7 == F7_ALT)
                    alu_op = ALU_SRA;
                else if ((funct3 == F3_SLL || funct3 == F3_SRL_SRA) && funct7 != F7_BASE)
                    illegal = 1'b1;
            end
            OPC_LUI:
            begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default:
            begin
                illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_dec.valid <= 1'b0;
        end
        else
        begin
            o_dec.valid <= i_instr_valid;
        end
        o_dec.illegal  <= illegal;
        o_dec.alu_op   <= alu_op;
        o_dec.use_imm  <= use_imm;
        o_dec.rs1      <= o_rs1_addr;
        o_dec.rs2      <= o_rs2_addr;
        o_dec.rd       <= rd;
        o_dec.imm      <= imm;
        o_dec.rs1_data <= i_rs1_data;
        o_dec.rs2_data <= i_rs2_data;
    end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_regfile
    import rv_pipe_pkg::*;
(
    input  wire         i_clk,
    input  reg_addr_t   i_rs1_addr,
    input  reg_addr_t   i_rs2_addr,
    output word_t       o_rs1_data,
    output word_t       o_rs2_data,
    input  wire         i_we,
    input  reg_addr_t   i_wr_addr,
    input  word_t       i_wr_data
);

    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // x0 is hardwired to zero.
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_execute
    import rv_pipe_pkg::*;
    import rv_isa_pkg::*;
(
    input  wire     i_clk,
    input  wire     i_rst,
    input  dec_t    i_dec,
    input  wb_t     i_res,
    output wb_t     o_ex
);

    word_t                  rs1_val;
    word_t                  rs2_val;
    word_t                  op_a;
    word_t                  op_b;
    word_t                  alu_res;
    logic [`RV_SHAMT_W-1:0] shamt;
    alu_op_t                alu_op;

    // Newest producer wins; register file value is the fallback.
    function automatic word_t fwd_sel(input reg_addr_t rs, input word_t rf_data,
                                      input wb_t ex, input wb_t res);
        word_t val;
        val = rf_data;
        if (rs != '0 && res.valid && !res.illegal && res.rd == rs)
        begin
            val = res.data;
        end
        if (rs != '0 && ex.valid && !ex.illegal && ex.rd == rs)
        begin
            val = ex.data;
        end
        return val;
    endfunction

    assign rs1_val = fwd_sel(i_dec.rs1, i_dec.rs1_data, o_ex, i_res);
    assign rs2_val = fwd_sel(i_dec.rs2, i_dec.rs2_data, o_ex, i_res);

    assign op_a   = rs1_val;
    assign op_b   = i_dec.use_imm ? i_dec.imm : rs2_val;
    assign shamt  = op_b[`RV_SHAMT_W-1:0];
    assign alu_op = alu_op_t'(i_dec.alu_op);

    always_comb
    begin
        case (alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = word_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> shamt);   // Sign fill.
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_ex.valid <= 1'b0;
        end
        else
        begin
            o_ex.valid <= i_dec.valid;
        end
        o_ex.illegal <= i_dec.illegal;
        o_ex.rd      <= i_dec.rd;
        o_ex.data    <= alu_res;
    end

endmodule

//--- rv_result.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_result
    import rv_pipe_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst,
    input  wb_t         i_ex,
    output wb_t         o_res,
    output logic        o_we,
    output reg_addr_t   o_wr_addr,
    output word_t       o_wr_data,
    output count_t      o_retire_count
);

    logic retire;

    assign retire = i_ex.valid && !i_ex.illegal;

    // Register file is written on the same edge that captures the entry.
    assign o_we      = retire && (i_ex.rd != '0);
    assign o_wr_addr = i_ex.rd;
    assign o_wr_data = i_ex.data;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_res.valid    <= 1'b0;
            o_retire_count <= '0;
        end
        else
        begin
            o_res.valid <= i_ex.valid;
            if (retire)
                o_retire_count <= o_retire_count + 1'b1;
        end
        o_res.illegal <= i_ex.illegal;
        o_res.rd      <= i_ex.rd;
        o_res.data    <= i_ex.data;
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module rv_core
    import rv_pipe_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst,
    input  wire         i_instr_valid,
    input  instr_t      i_instr,
    output logic        o_wb_valid,
    output reg_addr_t   o_wb_rd,
    output word_t       o_wb_data,
    output logic        o_illegal,
    output count_t      o_retire_count
);

    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    dec_t       dec;
    wb_t        ex;
    wb_t        res;
    logic       rf_we;
    reg_addr_t  rf_wr_addr;
    word_t      rf_wr_data;

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_rs1_addr     (rs1_addr),
        .o_rs2_addr     (rs2_addr),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .o_dec          (dec)
    );

    rv_regfile u_regfile
    (
        .i_clk          (i_clk),
        .i_rs1_addr     (rs1_addr),
        .i_rs2_addr     (rs2_addr),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data),
        .i_we           (rf_we),
        .i_wr_addr      (rf_wr_addr),
        .i_wr_data      (rf_wr_data)
    );

    rv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_dec          (dec),
        .i_res          (res),
        .o_ex           (ex)
    );

    rv_result u_result
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_ex           (ex),
        .o_res          (res),
        .o_we           (rf_we),
        .o_wr_addr      (rf_wr_addr),
        .o_wr_data      (rf_wr_data),
        .o_retire_count (o_retire_count)
    );

    assign o_wb_valid = res.valid && !res.illegal;
    assign o_illegal  = res.valid && res.illegal;
    assign o_wb_rd    = res.rd;
    assign o_wb_data  = res.data;

endmodule

//--- tb_rv_ref.svh
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

localparam logic [6:0] OPC_REG  = 7'b011_0011;
localparam logic [6:0] OPC_IMM  = 7'b001_0011;
localparam logic [6:0] OPC_LUI  = 7'b011_0111;
localparam logic [6:0] OPC_LOAD = 7'b000_0011;   // Not handled by the core.
localparam logic [6:0] F7_ALT   = 7'b010_0000;

// Expected result with the cycle its strobe was driven in.
typedef struct packed
{
    logic        illegal;
    reg_addr_t   rd;
    word_t       data;
    instr_t      instr;
    logic [31:0] issue_cycle;
} exp_t;

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

task automatic draw_bits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

// First seven instructions load x1 to x7, the rest are random.
task automatic gen_instr(input int n, output instr_t instr);
    logic [31:0] kind;
    logic [31:0] regs;
    logic [31:0] f3;
    logic [31:0] bits;
    logic [6:0]  f7;
    logic [11:0] imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    draw_bits(4, kind);
    draw_bits(9, regs);
    draw_bits(3, f3);
    draw_bits(20, bits);
    rd  = {2'b00, regs[2:0]};
    rs1 = {2'b00, regs[5:3]};
    rs2 = {2'b00, regs[8:6]};
    f7  = (bits[19] && (f3[2:0] == 3'd0 || f3[2:0] == 3'd5)) ? F7_ALT : 7'd0;
    imm = bits[11:0];
    if (f3[2:0] == 3'd1 || f3[2:0] == 3'd5)
        imm = {f7, bits[4:0]};               // Shift amount with SRAI select.
    if (n < 7)
        instr = {bits[11:0], 5'd0, 3'd0, reg_addr_t'(n + 1), OPC_IMM};
    else if (kind[3:0] == 4'd0)
    begin
        if (bits[13])
            instr = {F7_ALT, rs2, rs1, 3'd1, rd, OPC_IMM};
        else if (bits[12])
            instr = {7'd1, rs2, rs1, f3[2:0], rd, OPC_REG};
        else
            instr = {bits[19:0], rd, OPC_LOAD};
    end
    else if (kind[3:0] <= 4'd6)
        instr = {f7, rs2, rs1, f3[2:0], rd, OPC_REG};
    else if (kind[3:0] <= 4'd12)
        instr = {imm, rs1, f3[2:0], rd, OPC_IMM};
    else
        instr = {bits[19:0], rd, OPC_LUI};
endtask

function automatic exp_t ref_execute(input instr_t instr);
    exp_t       e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       alt;
    word_t      a;
    word_t      b;
    opc     = instr[6:0];
    f3      = instr[14:12];
    a       = ref_regs[instr[19:15]];
    b       = ref_regs[instr[24:20]];
    e       = '0;
    e.instr = instr;
    e.rd    = instr[11:7];
    alt     = (instr[31:25] == F7_ALT);
    if (opc == OPC_REG)
        e.illegal = !(instr[31:25] == 7'd0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
    else if (opc == OPC_IMM)
    begin
        b         = {{20{instr[31]}}, instr[31:20]};
        alt       = alt && (f3 == 3'd5);
        e.illegal = (f3 == 3'd1 || f3 == 3'd5) && !(instr[31:25] == 7'd0 || alt);
    end
    else
        e.illegal = (opc != OPC_LUI);
    case (f3)
        3'd0:    e.data = alt ? a - b : a + b;
        3'd1:    e.data = a << b[4:0];
        3'd2:    e.data = {31'd0, $signed(a) < $signed(b)};
        3'd3:    e.data = {31'd0, a < b};
        3'd4:    e.data = a ^ b;
        3'd5:    e.data = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    e.data = a | b;
        default: e.data = a & b;
    endcase
    if (opc == OPC_LUI)
        e.data = {instr[31:12], 12'h000};
    return e;
endfunction

`endif

//--- tb_rv_core.sv
`timescale 1ns/1ps

`include "rv_consts.svh"

module tb_rv_core
    import rv_pipe_pkg::*;
();

    localparam int NUM_INSTR      = 1500;
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = 3 * NUM_INSTR + 50;

    logic           i_clk;
    logic           i_rst;
    logic           i_instr_valid;
    instr_t         i_instr;
    logic           o_wb_valid;
    reg_addr_t      o_wb_rd;
    word_t          o_wb_data;
    logic           o_illegal;
    count_t         o_retire_count;

    logic [31:0]    lfsr_state;
    logic [31:0]    cycle_count = '0;
    word_t          ref_regs [`RV_NUM_REGS];
    int             value_errors;
    int             other_errors;
    int             legal_issued;
    int             legal_seen;

`include "tb_rv_ref.svh"

    exp_t           expect_q [$];

    rv_core i_rv_core
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data),
        .o_illegal      (o_illegal),
        .o_retire_count (o_retire_count)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
            value_errors++;
        end
    endtask

    // Outputs are sampled mid-cycle.
    always @(negedge i_clk)
    begin
        exp_t  e;
        string tag;
        if (!i_rst && (o_wb_valid || o_illegal))
        begin
            if (expect_q.size() == 0)
            begin
                $display("ERROR result pulse in cycle %0d with nothing in flight", cycle_count);
                other_errors++;
            end
            else
            begin
                e   = expect_q.pop_front();
                tag = $sformatf("instr %08h", e.instr);
                if (!e.illegal)
                    legal_seen++;
                check_value({tag, " illegal"}, 32'(e.illegal), 32'(o_illegal));
                check_value({tag, " wb_valid"}, 32'(!e.illegal), 32'(o_wb_valid));
                check_value({tag, " latency"}, LATENCY, cycle_count - e.issue_cycle);
                check_value({tag, " retire count"}, legal_seen, o_retire_count);
                if (!e.illegal)
                begin
                    check_value({tag, " rd"}, 32'(e.rd), 32'(o_wb_rd));
                    check_value({tag, " data"}, e.data, o_wb_data);
                end
            end
        end
    end

    initial
    begin
        int          n;
        instr_t      instr;
        exp_t        e;
        logic [31:0] gap;
        i_clk         = 1'b0;
        i_rst         = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        lfsr_state    = 32'hb479_00e2;
        value_errors  = 0;
        other_errors  = 0;
        legal_issued  = 0;
        legal_seen    = 0;
        foreach (ref_regs[r])
            ref_regs[r] = '0;
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_value("reset wb_valid", 0, 32'(o_wb_valid));
        check_value("reset illegal", 0, 32'(o_illegal));
        check_value("reset retire count", 0, o_retire_count);
        for (n = 0; n < NUM_INSTR; n++)
        begin
            gen_instr(n, instr);
            e = ref_execute(instr);
            if (!e.illegal && e.rd != '0)
                ref_regs[e.rd] = e.data;
            if (!e.illegal)
                legal_issued++;
            @(posedge i_clk);
            i_instr_valid <= 1'b1;
            i_instr       <= instr;
            e.issue_cycle = cycle_count + 1;        // Counter steps past this edge.
            expect_q.push_back(e);
            draw_bits(2, gap);
            repeat (gap % 3)
            begin
                @(posedge i_clk);
                i_instr_valid <= 1'b0;
            end
        end
        @(posedge i_clk);
        i_instr_valid <= 1'b0;
        while (expect_q.size() != 0)
            @(negedge i_clk);
        repeat (4) @(negedge i_clk);
        check_value("final retire count", legal_issued, o_retire_count);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        @(posedge i_clk);
        while (cycle_count < TIMEOUT_CYCLES)
            @(posedge i_clk);
        $display("ERROR run did not finish within %0d cycles, %0d results still pending",
                 TIMEOUT_CYCLES, expect_q.size());
        $display("Errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f compile.f -o tb_rv_core_sim
./obj_dir/tb_rv_core_sim | tee sim.log
if grep -q "Verification passed" sim.log
then
    exit 0
fi
exit 1
